// File: list.f
rtl/alu_pkg.sv
rtl/op_channel_if.sv
rtl/int_alu_comb.sv
rtl/mul_pipe.sv
rtl/operand_join.sv
rtl/alu_pipeline.sv
rtl/output_buffer.sv
rtl/elastic_alu.sv
verif/tb_clock.sv
verif/alu_asserts.sv
verif/tb_top.sv

// File: Bender.yml
package:
  name: elastic_alu

sources:
  - files:
      - rtl/alu_pkg.sv
      - rtl/op_channel_if.sv
      - rtl/int_alu_comb.sv
      - rtl/mul_pipe.sv
      - rtl/operand_join.sv
      - rtl/alu_pipeline.sv
      - rtl/output_buffer.sv
      - rtl/elastic_alu.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/alu_asserts.sv
      - verif/tb_top.sv

// File: verif/tb_top.sv
/*
 * testbench for the elastic operator unit
 * directed table, skewed operands, then random tokens with result stalls
 */
`timescale 1ns/1ps

module tb_top import alu_pkg::*; ();

	localparam int TIMEOUT = 1000;
	localparam logic [15:0] LFSR_SEED = 16'd21507;
	localparam logic [15:0] LFSR_TAPS = 16'hB400;

	typedef struct {
		alu_op_t op;
		word_t l;
		word_t r;
		word_t exp;
	} vec_t;

	logic clk;
	logic rst;
	word_t lhs;
	alu_op_t lhs_op;
	logic lhs_valid;
	logic lhs_ready;
	word_t rhs;
	logic rhs_valid;
	logic rhs_ready;
	word_t result;
	logic result_valid;
	logic result_ready;

	logic toggle_ready;
	logic [15:0] stim_state;
	logic [15:0] ready_state;
	word_t exp_q [$];
	int sent_count;
	int recv_count;
	int value_errors;
	int timeout_errors;
	int protocol_errors;
	int assert_errors;

	// opcode, L, R, expected
	vec_t vectors [20] = '{
		'{OP_ADD, 32'h0000_0005, 32'h0000_0007, 32'h0000_000C},
		'{OP_ADD, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000},
		'{OP_SUB, 32'h0000_0003, 32'h0000_0005, 32'hFFFF_FFFE},
		'{OP_MUL, 32'h0001_0003, 32'h0002_0005, 32'h000B_000F},
		'{OP_MUL, 32'hFFFF_FFFE, 32'h0000_0003, 32'hFFFF_FFFA},
		'{OP_MUL, 32'h8000_0001, 32'h8000_0001, 32'h0000_0001},
		'{OP_AND, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'hF000_F000},
		'{OP_OR, 32'hF0F0_F0F0, 32'h0F00_000F, 32'hFFF0_F0FF},
		'{OP_XOR, 32'hAAAA_AAAA, 32'hFFFF_0000, 32'h5555_AAAA},
		'{OP_SHL, 32'h0000_0001, 32'h0000_0024, 32'h0000_0010},
		'{OP_LSHR, 32'h8000_0000, 32'h0000_0004, 32'h0800_0000},
		'{OP_ASHR, 32'h8000_0000, 32'h0000_0004, 32'hF800_0000},
		'{OP_ASHR, 32'hF000_0000, 32'h0000_0023, 32'hFE00_0000},
		'{OP_EQ, 32'h1234_5678, 32'h1234_5678, 32'h0000_0001},
		'{OP_NE, 32'h1234_5678, 32'h1234_5678, 32'h0000_0000},
		'{OP_ULT, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000},
		'{OP_SLT, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001},
		'{OP_ULE, 32'h0000_0005, 32'h0000_0005, 32'h0000_0001},
		'{OP_SLE, 32'h0000_0001, 32'h8000_0000, 32'h0000_0000},
		'{OP_LSHR, 32'hF000_0000, 32'h0000_0021, 32'h7800_0000}
	};

	tb_clock #(.period_ns(100)) u_tb_clock (.clk(clk));

	elastic_alu #(
		.mul_stages(MUL_STAGES_DEF)
	) u_elastic_alu (
		.clk(clk),
		.rst(rst),
		.lhs(lhs),
		.lhs_op(lhs_op),
		.lhs_valid(lhs_valid),
		.lhs_ready(lhs_ready),
		.rhs(rhs),
		.rhs_valid(rhs_valid),
		.rhs_ready(rhs_ready),
		.result(result),
		.result_valid(result_valid),
		.result_ready(result_ready)
	);

	bind elastic_alu alu_asserts u_alu_asserts (
		.clk(clk),
		.rst(rst),
		.lhs_ready(lhs_ready),
		.rhs_ready(rhs_ready),
		.result(result),
		.result_valid(result_valid),
		.result_ready(result_ready)
	);

	// ------------------------------
	// random source and reference
	// ------------------------------
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ LFSR_TAPS;
		end
		return state >> 1;
	endfunction

	task automatic draw(inout logic [15:0] state, input int n, output word_t value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[DATA_W-2:0], state[0]};
			state = lfsr_step(state);
		end
	endtask

	function automatic word_t ref_result(input alu_op_t op, input word_t l, input word_t r);
		logic [2*DATA_W-1:0] wide;
		shamt_t sh;
		logic lt_s;
		sh = r[SHAMT_W-1:0];
		// differing signs decide by the sign of L alone
		lt_s = (l[DATA_W-1] != r[DATA_W-1]) ? l[DATA_W-1] : (l < r);
		case (op)
			OP_ADD: return l + r;
			OP_SUB: return l + ~r + 1;
			OP_MUL: begin
				wide = {{DATA_W{1'b0}}, l} * {{DATA_W{1'b0}}, r};
				return wide[DATA_W-1:0];
			end
			OP_AND: return l & r;
			OP_OR: return l | r;
			OP_XOR: return l ^ r;
			OP_SHL: return l << sh;
			OP_LSHR: return l >> sh;
			OP_ASHR: begin
				wide = {{DATA_W{l[DATA_W-1]}}, l} >> sh;
				return wide[DATA_W-1:0];
			end
			OP_EQ: return word_t'(l == r);
			OP_NE: return word_t'(l != r);
			OP_ULT: return word_t'(l < r);
			OP_ULE: return word_t'(!(r < l));
			OP_SLT: return word_t'(lt_s);
			OP_SLE: return word_t'(lt_s || (l == r));
			default: return '0;
		endcase
	endfunction

	// ------------------------------
	// checks
	// ------------------------------
	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		timeout_errors++;
	endtask

	// ------------------------------
	// drivers
	// ------------------------------
	task automatic drive_lhs(input alu_op_t op, input word_t l, input int delay);
		int waited;
		logic done;
		repeat (delay) @(negedge clk);
		lhs = l;
		lhs_op = op;
		lhs_valid = 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			done = lhs_ready;
			waited++;
		end while (!done && waited < TIMEOUT);
		if (!done) report_timeout("left operand transfer");
		@(negedge clk);
		lhs_valid = 1'b0;
	endtask

	task automatic drive_rhs(input word_t r, input int delay);
		int waited;
		logic done;
		repeat (delay) @(negedge clk);
		rhs = r;
		rhs_valid = 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			done = rhs_ready;
			waited++;
		end while (!done && waited < TIMEOUT);
		if (!done) report_timeout("right operand transfer");
		@(negedge clk);
		rhs_valid = 1'b0;
	endtask

	// starts and ends on a falling edge
	task automatic send_token(input alu_op_t op, input word_t l, input word_t r,
			input word_t exp, input int l_delay, input int r_delay);
		exp_q.push_back(exp);
		sent_count++;
		fork
			drive_lhs(op, l, l_delay);
			drive_rhs(r, r_delay);
		join
	endtask

	task automatic random_token(input logic gaps);
		word_t v;
		word_t l;
		word_t r;
		alu_op_t op;
		int l_delay;
		int r_delay;
		draw(stim_state, 4, v);
		op = alu_op_t'(4'(v % 15));
		draw(stim_state, 32, l);
		draw(stim_state, 32, r);
		l_delay = 0;
		r_delay = 0;
		if (gaps) begin
			draw(stim_state, 2, v);
			l_delay = v;
			draw(stim_state, 2, v);
			r_delay = v;
		end
		send_token(op, l, r, ref_result(op, l, r), l_delay, r_delay);
	endtask

	task automatic drain_results();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0) report_timeout("outstanding results");
		// a quiet window shows up duplicates
		repeat (MUL_STAGES_DEF + 2) @(negedge clk);
	endtask

	// result monitor
	always @(posedge clk) begin
		if (!rst && result_valid && result_ready) begin
			recv_count++;
			if (exp_q.size() == 0) begin
				$display("result %h returned with no token outstanding", result);
				protocol_errors++;
			end else begin
				check_word("result", result, exp_q.pop_front());
			end
		end
	end

	// random stall source on the result channel
	always @(negedge clk) begin
		word_t v;
		if (toggle_ready) begin
			draw(ready_state, 1, v);
			result_ready = v[0];
		end
	end

	initial begin
		rst = 1'b1;
		lhs = '0;
		lhs_op = OP_ADD;
		lhs_valid = 1'b0;
		rhs = '0;
		rhs_valid = 1'b0;
		result_ready = 1'b1;
		toggle_ready = 1'b0;
		stim_state = LFSR_SEED;
		ready_state = LFSR_SEED;
		sent_count = 0;
		recv_count = 0;
		value_errors = 0;
		timeout_errors = 0;
		protocol_errors = 0;
		assert_errors = 0;
		repeat (16) @(negedge clk);
		rst = 1'b0;

		// idle after reset
		repeat (10) begin
			@(negedge clk);
			check_bit("result_valid", result_valid, 1'b0);
			check_bit("lhs_ready", lhs_ready, 1'b1);
			check_bit("rhs_ready", rhs_ready, 1'b1);
		end

		foreach (vectors[i]) begin
			send_token(vectors[i].op, vectors[i].l, vectors[i].r, vectors[i].exp, 0, 0);
		end

		// L early, then R early
		for (int i = 0; i < 4; i++) begin
			send_token(vectors[i].op, vectors[i].l, vectors[i].r, vectors[i].exp, 0, 4);
		end
		for (int i = 4; i < 8; i++) begin
			send_token(vectors[i].op, vectors[i].l, vectors[i].r, vectors[i].exp, 4, 0);
		end

		repeat (100) random_token(1'b0);
		drain_results();
		check_word("result count", word_t'(recv_count), word_t'(sent_count));

		// stalls and gaps
		@(posedge clk);
		toggle_ready = 1'b1;
		@(negedge clk);
		repeat (150) random_token(1'b1);
		@(posedge clk);
		toggle_ready = 1'b0;
		@(negedge clk);
		result_ready = 1'b1;
		drain_results();
		check_word("result count", word_t'(recv_count), word_t'(sent_count));

		assert_errors = u_elastic_alu.u_alu_asserts.fail_count;
		$display("errors: %0d value, %0d timeout, %0d protocol, %0d assertion",
			value_errors, timeout_errors, protocol_errors, assert_errors);
		if (value_errors + timeout_errors + protocol_errors + assert_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: verif/alu_asserts.sv
/*
 * handshake checks on the elastic operator unit ports
 */
`timescale 1ns/1ps

module alu_asserts import alu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic lhs_ready,
	input logic rhs_ready,
	input word_t result,
	input logic result_valid,
	input logic result_ready
);

	// number of failed checks so far
	int fail_count = 0;

	// a stalled result must not move or vanish
	property result_held;
		@(posedge clk) disable iff (rst)
		(result_valid && !result_ready) |=> (result_valid && $stable(result));
	endproperty

	assert property (result_held)
		else begin
			$error("result changed while stalled");
			fail_count++;
		end

	assert property (@(posedge clk) rst |=> !result_valid)
		else begin
			$error("result_valid high after reset");
			fail_count++;
		end

	assert property (@(posedge clk) !$isunknown({lhs_ready, rhs_ready}))
		else begin
			$error("input ready is unknown");
			fail_count++;
		end

endmodule

// File: verif/tb_clock.sv
/*
 * testbench clock source, free running square wave
 */
`timescale 1ns/1ps

module tb_clock #(
	parameter int period_ns = 100
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(period_ns / 2) clk = ~clk;
		end
	end

endmodule

// File: rtl/elastic_alu.sv
/*
 * elastic integer operator unit, top level
 * operand join, operator pipeline and result buffer
 */
`timescale 1ns/1ps

module elastic_alu import alu_pkg::*; #(
	parameter int mul_stages = MUL_STAGES_DEF
) (
	input logic clk,
	input logic rst,
	input word_t lhs,
	input alu_op_t lhs_op,
	input logic lhs_valid,
	output logic lhs_ready,
	input word_t rhs,
	input logic rhs_valid,
	output logic rhs_ready,
	output word_t result,
	output logic result_valid,
	input logic result_ready
);

	logic pipe_valid;
	logic pipe_ready;
	word_t pipe_res;

	op_channel_if tok ();

	operand_join u_operand_join (
		.clk(clk),
		.rst(rst),
		.lhs(lhs),
		.lhs_op(lhs_op),
		.lhs_valid(lhs_valid),
		.lhs_ready(lhs_ready),
		.rhs(rhs),
		.rhs_valid(rhs_valid),
		.rhs_ready(rhs_ready),
		.tok(tok.src)
	);

	alu_pipeline #(
		.mul_stages(mul_stages)
	) u_alu_pipeline (
		.clk(clk),
		.rst(rst),
		.tok(tok.dst),
		.res_valid(pipe_valid),
		.res(pipe_res),
		.res_ready(pipe_ready)
	);

	output_buffer u_output_buffer (
		.clk(clk),
		.rst(rst),
		.in_valid(pipe_valid),
		.in_data(pipe_res),
		.in_ready(pipe_ready),
		.out_valid(result_valid),
		.out_data(result),
		.out_ready(result_ready)
	);

endmodule

// File: rtl/output_buffer.sv
/*
 * opaque half buffer on the result channel, one register stage
 */
`timescale 1ns/1ps

module output_buffer import alu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input word_t in_data,
	output logic in_ready,
	output logic out_valid,
	output word_t out_data,
	input logic out_ready
);

	// room when empty or when the held result leaves this cycle
	assign in_ready = ~out_valid | out_ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_data <= in_data;
		end
	end

endmodule

// File: rtl/alu_pipeline.sv
/*
 * operator pipeline, fixed latency for every opcode
 * early result rides alongside the multiplier and is picked at the end
 */
`timescale 1ns/1ps

module alu_pipeline import alu_pkg::*; #(
	parameter int mul_stages = MUL_STAGES_DEF
) (
	input logic clk,
	input logic rst,
	op_channel_if.dst tok,
	output logic res_valid,
	output word_t res,
	input logic res_ready
);

	localparam int DEPTH = mul_stages - 1;

	logic ce;
	word_t early;
	word_t product;
	logic [DEPTH-1:0] valid_q;
	alu_op_t op_q [DEPTH];
	word_t early_q [DEPTH];

	// whole pipe stalls together, bubbles included
	assign ce = res_ready;
	assign tok.ready = ce;

	int_alu_comb u_int_alu_comb (
		.op(tok.op),
		.lhs(tok.lhs),
		.rhs(tok.rhs),
		.res(early)
	);

	mul_pipe #(
		.mul_stages(mul_stages)
	) u_mul_pipe (
		.clk(clk),
		.ce(ce),
		.a(tok.lhs),
		.b(tok.rhs),
		.p(product)
	);

	// ------------------------------
	// stage registers
	// ------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= '0;
		end else if (ce) begin
			valid_q[0] <= tok.valid;
			for (int i = 1; i < DEPTH; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ce) begin
			op_q[0] <= tok.op;
			early_q[0] <= early;
			for (int i = 1; i < DEPTH; i++) begin
				op_q[i] <= op_q[i-1];
				early_q[i] <= early_q[i-1];
			end
		end
	end

	// final select, product only for mul
	assign res_valid = valid_q[DEPTH-1];
	assign res = (op_q[DEPTH-1] == OP_MUL) ? product : early_q[DEPTH-1];

endmodule

// File: rtl/operand_join.sv
/*
 * operand join, merges the left and right channels into one token
 * a transparent half buffer keeps the input readies off the stall path
 */
`timescale 1ns/1ps

module operand_join import alu_pkg::*; (
	input logic clk,
	input logic rst,
	input word_t lhs,
	input alu_op_t lhs_op,
	input logic lhs_valid,
	output logic lhs_ready,
	input word_t rhs,
	input logic rhs_valid,
	output logic rhs_ready,
	op_channel_if.src tok
);

	logic join_valid;
	logic full;
	alu_op_t held_op;
	word_t held_lhs;
	word_t held_rhs;

	// token exists only once both sides have arrived
	assign join_valid = lhs_valid & rhs_valid;

	// an idle side is always ready; a waiting side goes with its partner
	assign lhs_ready = ~lhs_valid | (rhs_valid & ~full);
	assign rhs_ready = ~rhs_valid | (lhs_valid & ~full);

	// ------------------------------
	// transparent half buffer
	// ------------------------------
	assign tok.valid = join_valid | full;
	assign tok.op = full ? held_op : lhs_op;
	assign tok.lhs = full ? held_lhs : lhs;
	assign tok.rhs = full ? held_rhs : rhs;

	// slot fills when a presented token is refused downstream
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			full <= 1'b0;
		end else begin
			full <= tok.valid & ~tok.ready;
		end
	end

	// follow the inputs while empty, freeze once full
	always_ff @(posedge clk) begin
		if (!full) begin
			held_op <= lhs_op;
			held_lhs <= lhs;
			held_rhs <= rhs;
		end
	end

endmodule

// File: rtl/mul_pipe.sv
/*
 * pipelined multiplier, low word of the product
 * partial products in the first stage, sum and delay after that
 */
`timescale 1ns/1ps

module mul_pipe import alu_pkg::*; #(
	parameter int mul_stages = MUL_STAGES_DEF
) (
	input logic clk,
	input logic ce,
	input word_t a,
	input word_t b,
	output word_t p
);

	localparam int DEPTH = mul_stages - 1;
	localparam int HALF = DATA_W / 2;

	word_t pp_low_q;
	logic [HALF-1:0] pp_cross_q;
	word_t sum;

	// high half times high half falls outside the low word
	always_ff @(posedge clk) begin
		if (ce) begin
			pp_low_q <= a[HALF-1:0] * b[HALF-1:0];
			pp_cross_q <= a[HALF-1:0] * b[DATA_W-1:HALF] + a[DATA_W-1:HALF] * b[HALF-1:0];
		end
	end

	assign sum = pp_low_q + {pp_cross_q, {HALF{1'b0}}};

	generate
		if (DEPTH == 1) begin : g_single
			assign p = sum;
		end else begin : g_chain
			word_t prod_q [DEPTH-1];

			always_ff @(posedge clk) begin
				if (ce) begin
					prod_q[0] <= sum;
					for (int i = 1; i < DEPTH - 1; i++) begin
						prod_q[i] <= prod_q[i-1];
					end
				end
			end

			assign p = prod_q[DEPTH-2];
		end
	endgenerate

endmodule

// File: rtl/int_alu_comb.sv
/*
 * single cycle integer operations on one token
 * arithmetic, bitwise logic, shifts and compares
 */
`timescale 1ns/1ps

module int_alu_comb import alu_pkg::*; (
	input alu_op_t op,
	input word_t lhs,
	input word_t rhs,
	output word_t res
);

	shamt_t shamt;

	// larger amounts wrap onto the low bits
	assign shamt = rhs[SHAMT_W-1:0];

	always_comb begin
		res = '0;
		case (op)
			OP_ADD: res = lhs + rhs;
			OP_SUB: res = lhs - rhs;
			OP_AND: res = lhs & rhs;
			OP_OR: res = lhs | rhs;
			OP_XOR: res = lhs ^ rhs;
			OP_SHL: res = lhs << shamt;
			OP_LSHR: res = lhs >> shamt;
			// sign bit fills from the left
			OP_ASHR: res = $signed(lhs) >>> shamt;
			// compares leave a flag in bit 0, upper bits stay clear
			OP_EQ: res[0] = (lhs == rhs);
			OP_NE: res[0] = (lhs != rhs);
			OP_ULT: res[0] = (lhs < rhs);
			OP_ULE: res[0] = (lhs <= rhs);
			OP_SLT: res[0] = ($signed(lhs) < $signed(rhs));
			OP_SLE: res[0] = ($signed(lhs) <= $signed(rhs));
			// product comes from the multiplier pipe
			default: res = '0;
		endcase
	end

endmodule

// File: rtl/op_channel_if.sv
/*
 * joined operand token, from the operand join into the operator pipeline
 */
`timescale 1ns/1ps

interface op_channel_if import alu_pkg::*; ();

	logic valid;
	logic ready;
	alu_op_t op;
	word_t lhs;
	word_t rhs;

	// join side presents the token
	modport src (
		output valid, op, lhs, rhs,
		input ready
	);

	// pipeline side accepts it
	modport dst (
		input valid, op, lhs, rhs,
		output ready
	);

endinterface

// File: rtl/alu_pkg.sv
/*
 * elastic integer operator unit, shared types
 * operand and shift widths, opcode encoding, default pipeline depth
 */
package alu_pkg;

	// ------------------------------
	// data widths
	// ------------------------------
	localparam int DATA_W = 32;

	typedef logic [DATA_W-1:0] word_t;

	// only the low bits of the right operand steer a shift
	localparam int SHAMT_W = 5;

	typedef logic [SHAMT_W-1:0] shamt_t;

	// ------------------------------
	// opcodes
	// ------------------------------
	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_MUL  = 4'd2,
		OP_AND  = 4'd3,
		OP_OR   = 4'd4,
		OP_XOR  = 4'd5,
		OP_SHL  = 4'd6,
		OP_LSHR = 4'd7,
		OP_ASHR = 4'd8,
		OP_EQ   = 4'd9,
		OP_NE   = 4'd10,
		OP_ULT  = 4'd11,
		OP_ULE  = 4'd12,
		OP_SLT  = 4'd13,
		OP_SLE  = 4'd14
	} alu_op_t;

	// latency of the operator pipeline, output buffer included
	localparam int MUL_STAGES_DEF = 4;

endpackage
